// ==== src/rv_tail_pkg.sv ====
// Shared types for the RV32I memory and write-back tail
// XLEN is fixed at 32 and there is no MMU, so no page-fault fields
// Only the major opcodes the tail needs are enumerated
`default_nettype none

package rv_tail_pkg;

  // Data and address width
  localparam int xlen = 32;

  //////////////////////////////////////////////////
  // Encodings

  // Major opcodes, instruction bits [6:2]
  typedef enum logic [4:0] {
    opc_load     = 5'b00000,
    opc_misc_mem = 5'b00011,
    opc_op_imm   = 5'b00100,
    opc_store    = 5'b01000,
    opc_op       = 5'b01100,
    opc_lui      = 5'b01101,
    opc_branch   = 5'b11000,
    opc_system   = 5'b11100
  } opcode_e;

  // Load kinds, same values as funct3
  typedef enum logic [2:0] {
    lk_lb  = 3'b000,
    lk_lh  = 3'b001,
    lk_lw  = 3'b010,
    lk_lbu = 3'b100,
    lk_lhu = 3'b101
  } load_kind_e;

  //////////////////////////////////////////////////
  // Pipeline and memory records

  typedef struct packed {
    logic [31:0] instr;
    logic        bubble;
    logic        retired;
  } instruction_t;

  // Summary bit any is the OR of all others
  typedef struct packed {
    logic illegal_instruction;
    logic breakpoint;
    logic misaligned_load;
    logic misaligned_store;
    logic load_access_fault;
    logic store_access_fault;
    logic nmi;
    logic any;
  } exceptions_t;

  // Size 0 byte, 1 half, 2 word, 3 reserved
  typedef struct packed {
    logic            req;
    logic            we;
    logic [1:0]      size;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
  } dmem_req_t;

  typedef struct packed {
    logic            ack;
    logic            err;
    logic            misaligned;
    logic [xlen-1:0] rdata;
  } dmem_rsp_t;

  //////////////////////////////////////////////////
  // Decoders

  function automatic opcode_e decode_opcode(input logic [31:0] instr);
    return opcode_e'(instr[6:2]);
  endfunction

  function automatic logic [4:0] decode_rd(input logic [31:0] instr);
    return instr[11:7];
  endfunction

  // Reserved funct3 values fall back to a word load
  function automatic load_kind_e decode_load_kind(input logic [31:0] instr);
    load_kind_e kind;
    case (instr[14:12])
      3'b000:  kind = lk_lb;
      3'b001:  kind = lk_lh;
      3'b100:  kind = lk_lbu;
      3'b101:  kind = lk_lhu;
      default: kind = lk_lw;
    endcase
    return kind;
  endfunction

endpackage

`default_nettype wire

// ==== src/rv_dmem.sv ====
// Word-organised data memory with a fixed response latency
// DMEM_WORDS must be 2 or more, DMEM_LATENCY 1 or more
// Request must stay stable until its response cycle
// Misaligned accesses answer at once and never touch the array
`timescale 1ns/1ps
`default_nettype none

module rv_dmem #(
  parameter int DMEM_WORDS   = 256,
  parameter int DMEM_LATENCY = 2
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  rv_tail_pkg::dmem_req_t req_i,
  output rv_tail_pkg::dmem_rsp_t rsp_o
);

  localparam int IDX_W = $clog2(DMEM_WORDS);
  localparam int CNT_W = $clog2(DMEM_LATENCY + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DMEM_LATENCY);

  typedef enum logic {
    st_idle,
    st_wait
  } state_e;

  state_e             state_q;
  logic [CNT_W-1:0]   cnt_q;
  logic [31:0]        mem [DMEM_WORDS];
  logic [IDX_W-1:0]   idx;
  logic               in_range;
  logic               misaligned;
  logic               resp_now;
  logic [3:0]         byte_en;
  logic [31:0]        wdata_sh;

  //////////////////////////////////////////////////
  // Address checks

  assign idx      = req_i.addr[2 +: IDX_W];
  assign in_range = req_i.addr[31:2] < 30'(DMEM_WORDS);

  // Reserved size 3 counts as misaligned
  always_comb
  begin
    case (req_i.size)
      2'd0:    misaligned = 1'b0;
      2'd1:    misaligned = req_i.addr[0];
      2'd2:    misaligned = |req_i.addr[1:0];
      default: misaligned = 1'b1;
    endcase
  end

  // Final wait cycle is the response cycle
  assign resp_now = (state_q == st_wait) && (cnt_q == CNT_LAST);

  assign rsp_o.ack        = resp_now && in_range;
  assign rsp_o.err        = resp_now && !in_range;
  assign rsp_o.misaligned = (state_q == st_idle) && req_i.req && misaligned;
  assign rsp_o.rdata      = in_range ? mem[idx] : 32'h0;

  //////////////////////////////////////////////////
  // Latency FSM

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= st_idle;
      cnt_q   <= '0;
    end
    else
    begin
      case (state_q)
        st_idle:
          if (req_i.req && !misaligned)
          begin
            state_q <= st_wait;
            cnt_q   <= CNT_W'(1);
          end
        default:
          if (resp_now)
          begin
            state_q <= st_idle;
            cnt_q   <= '0;
          end
          else
            cnt_q <= cnt_q + CNT_W'(1);
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Byte-lane store

  // Store data arrives in the low bits
  assign wdata_sh = req_i.wdata << (8 * req_i.addr[1:0]);

  always_comb
  begin
    case (req_i.size)
      2'd0:    byte_en = 4'b0001 << req_i.addr[1:0];
      2'd1:    byte_en = 4'b0011 << req_i.addr[1:0];
      default: byte_en = 4'b1111;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (resp_now && in_range && req_i.we)
    begin
      for (int b = 0; b < 4; b++)
        if (byte_en[b])
          mem[idx][8*b +: 8] <= wdata_sh[8*b +: 8];
    end
  end

endmodule

`default_nettype wire

// ==== src/rv_wb.sv ====
// RV32I memory-wait and write-back stage
// Upstream must hold its record while wb_stall_o is high
// A record with an incoming exception must not raise a memory request
`timescale 1ns/1ps
`default_nettype none

module rv_wb #(
  parameter logic [rv_tail_pkg::xlen-1:0] PC_INIT = 'h200
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  output logic                           wb_stall_o,
  input  logic [rv_tail_pkg::xlen-1:0]   mem_pc_i,
  output logic [rv_tail_pkg::xlen-1:0]   wb_pc_o,
  input  rv_tail_pkg::instruction_t      mem_insn_i,
  output rv_tail_pkg::instruction_t      wb_insn_o,
  input  rv_tail_pkg::exceptions_t       mem_exceptions_i,
  output rv_tail_pkg::exceptions_t       wb_exceptions_o,
  output logic [rv_tail_pkg::xlen-1:0]   wb_badaddr_o,
  input  logic [rv_tail_pkg::xlen-1:0]   mem_r_i,
  input  logic [rv_tail_pkg::xlen-1:0]   mem_memadr_i,
  input  rv_tail_pkg::dmem_rsp_t         dmem_rsp_i,
  output logic [rv_tail_pkg::xlen-1:0]   wb_memq_o,
  output logic [4:0]                     wb_dst_o,
  output logic [rv_tail_pkg::xlen-1:0]   wb_r_o,
  output logic                           wb_we_o
);

  rv_tail_pkg::opcode_e      opcode;
  rv_tail_pkg::load_kind_e   load_kind;
  rv_tail_pkg::exceptions_t  exceptions;
  logic [4:0]                dst;
  logic                      is_load;
  logic                      is_store;
  logic [31:0]               instr_q;
  logic                      bubble_q;
  logic                      retired_q;
  logic [7:0]                q_byte;
  logic [15:0]               q_half;

  assign opcode    = rv_tail_pkg::decode_opcode(mem_insn_i.instr);
  assign load_kind = rv_tail_pkg::decode_load_kind(mem_insn_i.instr);
  assign dst       = rv_tail_pkg::decode_rd(mem_insn_i.instr);

  // Live memory operations only
  assign is_load  = !mem_insn_i.bubble && (opcode == rv_tail_pkg::opc_load);
  assign is_store = !mem_insn_i.bubble && (opcode == rv_tail_pkg::opc_store);

  //////////////////////////////////////////////////
  // Stall and fault merging

  // Wait for exactly one response cycle
  assign wb_stall_o = (is_load || is_store) && !mem_exceptions_i.any &&
                      !(dmem_rsp_i.ack || dmem_rsp_i.err || dmem_rsp_i.misaligned);

  always_comb
  begin
    exceptions = mem_exceptions_i;
    if (is_load)
    begin
      exceptions.misaligned_load   = dmem_rsp_i.misaligned;
      exceptions.load_access_fault = dmem_rsp_i.err;
    end
    if (is_store)
    begin
      exceptions.misaligned_store   = dmem_rsp_i.misaligned;
      exceptions.store_access_fault = dmem_rsp_i.err;
    end
    // Recompute summary after the merge
    exceptions.any = exceptions.illegal_instruction | exceptions.breakpoint |
                     exceptions.misaligned_load | exceptions.misaligned_store |
                     exceptions.load_access_fault | exceptions.store_access_fault |
                     exceptions.nmi;
  end

  //////////////////////////////////////////////////
  // Pipeline record

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wb_pc_o         <= PC_INIT;
      wb_exceptions_o <= '0;
      wb_badaddr_o    <= '0;
      bubble_q        <= 1'b1;
    end
    else if (!wb_stall_o)
    begin
      wb_pc_o         <= mem_pc_i;
      wb_exceptions_o <= exceptions;
      // Record after a fault is flushed
      bubble_q        <= mem_insn_i.bubble | wb_exceptions_o.any;
      // Memory faults and breakpoints report the address
      if (exceptions.misaligned_load || exceptions.misaligned_store ||
          exceptions.load_access_fault || exceptions.store_access_fault ||
          exceptions.breakpoint)
        wb_badaddr_o <= mem_memadr_i;
      else if (exceptions.illegal_instruction)
        wb_badaddr_o <= mem_insn_i.instr;
      else
        wb_badaddr_o <= '0;
    end
  end

  // Faulting, flushed and stalled records never retire
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      retired_q <= 1'b0;
    else if (wb_stall_o || exceptions.any || wb_exceptions_o.any)
      retired_q <= 1'b0;
    else
      retired_q <= mem_insn_i.retired;
  end

  // Instruction word, destination and result
  always_ff @(posedge clk_i)
  begin
    if (!wb_stall_o)
    begin
      instr_q  <= mem_insn_i.instr;
      wb_dst_o <= dst;
      wb_r_o   <= is_load ? wb_memq_o : mem_r_i;
    end
  end

  assign wb_insn_o = '{instr: instr_q, bubble: bubble_q, retired: retired_q};

  //////////////////////////////////////////////////
  // Load data alignment

  assign q_byte = dmem_rsp_i.rdata[8*mem_memadr_i[1:0] +: 8];
  assign q_half = dmem_rsp_i.rdata[8*{mem_memadr_i[1], 1'b0} +: 16];

  always_comb
  begin
    case (load_kind)
      rv_tail_pkg::lk_lb:  wb_memq_o = {{24{q_byte[7]}}, q_byte};
      rv_tail_pkg::lk_lh:  wb_memq_o = {{16{q_half[15]}}, q_half};
      rv_tail_pkg::lk_lbu: wb_memq_o = {24'h0, q_byte};
      rv_tail_pkg::lk_lhu: wb_memq_o = {16'h0, q_half};
      default:             wb_memq_o = dmem_rsp_i.rdata;
    endcase
  end

  //////////////////////////////////////////////////
  // Register file write enable

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      wb_we_o <= 1'b0;
    else if (wb_stall_o || exceptions.any || wb_exceptions_o.any)
      wb_we_o <= 1'b0;
    else
    begin
      case (opcode)
        rv_tail_pkg::opc_store,
        rv_tail_pkg::opc_branch,
        rv_tail_pkg::opc_misc_mem: wb_we_o <= 1'b0;
        default:                   wb_we_o <= !mem_insn_i.bubble && (dst != 5'd0);
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/rv_regfile.sv ====
// Integer register file, one write and one read port
// x0 reads as zero and ignores writes, read port is combinational
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         we_i,
  input  logic [4:0]                   waddr_i,
  input  logic [rv_tail_pkg::xlen-1:0] wdata_i,
  input  logic [4:0]                   raddr_i,
  output logic [rv_tail_pkg::xlen-1:0] rdata_o
);

  // x1 to x31 only
  logic [rv_tail_pkg::xlen-1:0] regs_q [1:31];

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      for (int i = 1; i < 32; i++)
        regs_q[i] <= '0;
    end
    else if (we_i && (waddr_i != 5'd0))
      regs_q[waddr_i] <= wdata_i;
  end

  // New value visible the cycle after the write
  assign rdata_o = (raddr_i == 5'd0) ? '0 : regs_q[raddr_i];

endmodule

`default_nettype wire

// ==== src/rv_mem_tail.sv ====
// Back end of an in-order RV32I pipeline
// Upstream holds record and memory request while wb_stall_o is high
// rf_raddr_i stands in for the operand read port
`timescale 1ns/1ps
`default_nettype none

module rv_mem_tail #(
  parameter logic [rv_tail_pkg::xlen-1:0] PC_INIT      = 'h200,
  parameter int                           DMEM_WORDS   = 256,
  parameter int                           DMEM_LATENCY = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Record from execute
  input  logic [rv_tail_pkg::xlen-1:0] mem_pc_i,
  input  rv_tail_pkg::instruction_t    mem_insn_i,
  input  logic [rv_tail_pkg::xlen-1:0] mem_r_i,
  input  logic [rv_tail_pkg::xlen-1:0] mem_memadr_i,
  input  rv_tail_pkg::exceptions_t     mem_exceptions_i,
  input  rv_tail_pkg::dmem_req_t       mem_req_i,
  // Operand read port
  input  logic [4:0]                   rf_raddr_i,
  output logic [rv_tail_pkg::xlen-1:0] rf_rdata_o,
  // Write-back record
  output logic                         wb_stall_o,
  output logic [rv_tail_pkg::xlen-1:0] wb_pc_o,
  output rv_tail_pkg::instruction_t    wb_insn_o,
  output rv_tail_pkg::exceptions_t     wb_exceptions_o,
  output logic [rv_tail_pkg::xlen-1:0] wb_badaddr_o,
  output logic [rv_tail_pkg::xlen-1:0] wb_memq_o
);

  rv_tail_pkg::dmem_rsp_t       dmem_rsp;
  logic [4:0]                   wb_dst;
  logic [rv_tail_pkg::xlen-1:0] wb_r;
  logic                         wb_we;

  rv_dmem #(
    .DMEM_WORDS   (DMEM_WORDS),
    .DMEM_LATENCY (DMEM_LATENCY)
  ) rv_dmem_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (mem_req_i),
    .rsp_o  (dmem_rsp)
  );

  rv_wb #(
    .PC_INIT (PC_INIT)
  ) rv_wb_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .wb_stall_o       (wb_stall_o),
    .mem_pc_i         (mem_pc_i),
    .wb_pc_o          (wb_pc_o),
    .mem_insn_i       (mem_insn_i),
    .wb_insn_o        (wb_insn_o),
    .mem_exceptions_i (mem_exceptions_i),
    .wb_exceptions_o  (wb_exceptions_o),
    .wb_badaddr_o     (wb_badaddr_o),
    .mem_r_i          (mem_r_i),
    .mem_memadr_i     (mem_memadr_i),
    .dmem_rsp_i       (dmem_rsp),
    .wb_memq_o        (wb_memq_o),
    .wb_dst_o         (wb_dst),
    .wb_r_o           (wb_r),
    .wb_we_o          (wb_we)
  );

  rv_regfile rv_regfile_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .we_i    (wb_we),
    .waddr_i (wb_dst),
    .wdata_i (wb_r),
    .raddr_i (rf_raddr_i),
    .rdata_o (rf_rdata_o)
  );

endmodule

`default_nettype wire

// ==== tb/tb_rv_mem_tail.sv ====
// Testbench for the RV32I memory and write-back tail
// Assumes default parameters, PC_INIT 0x200, 256 words, latency 2
// Inputs change on the falling edge, outputs sampled before the next rise
`timescale 1ns/1ps
`default_nettype none

module tb_rv_mem_tail;

  localparam int LATENCY    = 2;
  localparam int WAIT_LIMIT = 20;
  localparam int RUN_LIMIT  = 5000;
  // Bit positions inside exceptions_t
  localparam int FLT_ILLEGAL = 7;
  localparam int FLT_BREAK   = 6;
  localparam int FLT_MIS_LD  = 5;
  localparam int FLT_MIS_ST  = 4;
  localparam int FLT_LD_AF   = 3;
  localparam int FLT_ST_AF   = 2;

  logic                      clk_i;
  logic                      rst_ni;
  logic [31:0]               mem_pc_i;
  rv_tail_pkg::instruction_t mem_insn_i;
  logic [31:0]               mem_r_i;
  logic [31:0]               mem_memadr_i;
  rv_tail_pkg::exceptions_t  mem_exceptions_i;
  rv_tail_pkg::dmem_req_t    mem_req_i;
  logic [4:0]                rf_raddr_i;
  logic [31:0]               rf_rdata_o;
  logic                      wb_stall_o;
  logic [31:0]               wb_pc_o;
  rv_tail_pkg::instruction_t wb_insn_o;
  rv_tail_pkg::exceptions_t  wb_exceptions_o;
  logic [31:0]               wb_badaddr_o;
  logic [31:0]               wb_memq_o;

  // Shadow models
  logic [7:0]  shadow_mem [1024];
  logic [31:0] shadow_regs [32];
  logic [31:0] rng_state;
  logic [31:0] next_pc;
  logic [31:0] last_memq;
  int          stall_cycles;
  int          errors;
  int          assert_errors;
  int          tests_passed;
  int          tests_failed;
  logic        done;
  logic        timed_out;

  rv_mem_tail rv_mem_tail_i (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // An incoming exception never waits for memory
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   mem_exceptions_i.any |-> !wb_stall_o)
  else
  begin
    $display("Stall raised for a record that carries an exception");
    assert_errors++;
  end

  ////////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic logic [4:0] pick_rd(input logic [31:0] r);
    return (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
  endfunction

  // I-type style word with other fields zero
  function automatic logic [31:0] make_insn(input rv_tail_pkg::opcode_e opc,
                                            input logic [2:0] f3, input logic [4:0] rd);
    return {17'h0, f3, rd, opc, 2'b11};
  endfunction

  function automatic rv_tail_pkg::exceptions_t one_fault(input int bit_pos);
    logic [7:0] v;
    v = 8'h01 | (8'h01 << bit_pos);
    return rv_tail_pkg::exceptions_t'(v);
  endfunction

  // Little-endian bytes, then sign or zero extension by funct3
  function automatic logic [31:0] expect_load(input logic [2:0] f3, input logic [31:0] addr);
    logic [7:0]  b;
    logic [15:0] h;
    logic [31:0] w;
    b = shadow_mem[addr[9:0]];
    h = {shadow_mem[addr[9:0] + 10'd1], b};
    w = {shadow_mem[addr[9:0] + 10'd3], shadow_mem[addr[9:0] + 10'd2], h};
    case (f3)
      3'b000:  return {{24{b[7]}}, b};
      3'b001:  return {{16{h[15]}}, h};
      3'b100:  return {24'h0, b};
      3'b101:  return {16'h0, h};
      default: return w;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // Present one record and follow it until accepted
  task automatic issue(input logic [31:0] instr, input logic bubble, input logic [31:0] r,
                       input logic [31:0] adr, input rv_tail_pkg::exceptions_t exc,
                       input logic req, input logic we, input logic [31:0] wdata);
    logic [31:0] prev_pc;
    int          guard;
    prev_pc            = wb_pc_o;
    next_pc            = next_pc + 32'd4;
    mem_pc_i           = next_pc;
    mem_insn_i.instr   = instr;
    mem_insn_i.bubble  = bubble;
    mem_insn_i.retired = !bubble;
    mem_r_i            = r;
    mem_memadr_i       = adr;
    mem_exceptions_i   = exc;
    mem_req_i.req      = req;
    mem_req_i.we       = we;
    mem_req_i.size     = instr[13:12];
    mem_req_i.addr     = adr;
    mem_req_i.wdata    = wdata;
    stall_cycles       = 0;
    guard              = 0;
    #1;
    // Earlier pc must stay while the record is held
    while (wb_stall_o && guard < WAIT_LIMIT)
    begin
      check_value("wb_pc_o", wb_pc_o, prev_pc);
      stall_cycles++;
      guard++;
      @(negedge clk_i);
      #1;
    end
    if (wb_stall_o)
    begin
      $display("Timeout waiting for wb_stall_o to drop after %0d cycles", WAIT_LIMIT);
      timed_out = 1'b1;
    end
    last_memq = wb_memq_o;
    @(negedge clk_i);
    check_value("wb_pc_o", wb_pc_o, mem_pc_i);
    check_value("wb_insn_o.instr", wb_insn_o.instr, instr);
  endtask

  task automatic idle_cycle();
    issue(32'h0, 1'b1, 32'h0, 32'h0, '0, 1'b0, 1'b0, 32'h0);
  endtask

  // Write lands one edge after acceptance
  task automatic check_reg(input logic [4:0] rd);
    rf_raddr_i = rd;
    idle_cycle();
    check_value("rf_rdata_o", rf_rdata_o, shadow_regs[rd]);
  endtask

  // Faulting record writes nothing and flushes the record behind it
  task automatic check_fault(input logic [4:0] rd, input int exp_stalls,
                             input rv_tail_pkg::exceptions_t exp_exc,
                             input logic [31:0] exp_badaddr);
    check_value("stall cycles", 32'(stall_cycles), 32'(exp_stalls));
    check_value("wb_exceptions_o", 32'(wb_exceptions_o), 32'(exp_exc));
    check_value("wb_badaddr_o", wb_badaddr_o, exp_badaddr);
    check_value("wb_insn_o.retired", 32'(wb_insn_o.retired), 32'h0);
    rf_raddr_i = rd;
    issue(make_insn(rv_tail_pkg::opc_op, 3'b000, rd), 1'b0, next_random(), 32'h0, '0,
          1'b0, 1'b0, 32'h0);
    check_value("wb_insn_o.bubble", 32'(wb_insn_o.bubble), 32'h1);
    check_value("wb_insn_o.retired", 32'(wb_insn_o.retired), 32'h0);
    idle_cycle();
    check_value("rf_rdata_o", rf_rdata_o, shadow_regs[rd]);
  endtask

  task automatic end_test(input string name, input int errors_at_start);
    if (errors == errors_at_start)
    begin
      tests_passed++;
      $display("PASS %s", name);
    end
    else
    begin
      tests_failed++;
      $display("FAIL %s with %0d errors", name, errors - errors_at_start);
    end
  endtask

  ////////////////////////////////////////////////////
  // Stimulus

  initial
  begin
    logic [4:0]  rd;
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] word_addr [6];
    logic [2:0]  kinds [5];
    int          start;
    rng_state     = 32'd39;
    errors        = 0;
    assert_errors = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    done          = 1'b0;
    timed_out     = 1'b0;
    next_pc       = 32'h1000;
    kinds         = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
    rst_ni           = 1'b0;
    mem_pc_i         = '0;
    mem_insn_i       = '{instr: 32'h0, bubble: 1'b1, retired: 1'b0};
    mem_r_i          = '0;
    mem_memadr_i     = '0;
    mem_exceptions_i = '0;
    mem_req_i        = '0;
    rf_raddr_i       = '0;
    for (int i = 0; i < 32; i++)
    begin
      shadow_regs[i] = '0;
    end
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;

    // Reset values before the first edge out of reset
    start = errors;
    check_value("wb_pc_o", wb_pc_o, 32'h200);
    check_value("wb_insn_o.bubble", 32'(wb_insn_o.bubble), 32'h1);
    check_value("wb_insn_o.retired", 32'(wb_insn_o.retired), 32'h0);
    check_value("wb_exceptions_o", 32'(wb_exceptions_o), 32'h0);
    check_value("wb_stall_o", 32'(wb_stall_o), 32'h0);
    for (int i = 0; i < 32; i++)
    begin
      rf_raddr_i = 5'(i);
      @(negedge clk_i);
      check_value("rf_rdata_o", rf_rdata_o, 32'h0);
    end
    end_test("reset values", start);

    // ALU results, then records that must not write
    start = errors;
    for (int n = 0; n < 8; n++)
    begin
      r  = next_random();
      rd = pick_rd(next_random());
      issue(make_insn(n[0] ? rv_tail_pkg::opc_op_imm : rv_tail_pkg::opc_op, 3'b000, rd),
            1'b0, r, 32'h0, '0, 1'b0, 1'b0, 32'h0);
      check_value("wb_insn_o.retired", 32'(wb_insn_o.retired), 32'h1);
      shadow_regs[rd] = r;
      check_reg(rd);
    end
    issue(make_insn(rv_tail_pkg::opc_op, 3'b000, 5'd0), 1'b0, next_random(), 32'h0, '0,
          1'b0, 1'b0, 32'h0);
    check_reg(5'd0);
    issue(make_insn(rv_tail_pkg::opc_op, 3'b000, rd), 1'b1, next_random(), 32'h0, '0,
          1'b0, 1'b0, 32'h0);
    check_reg(rd);
    issue(make_insn(rv_tail_pkg::opc_branch, 3'b000, rd), 1'b0, next_random(), 32'h0, '0,
          1'b0, 1'b0, 32'h0);
    check_reg(rd);
    end_test("alu writes", start);

    // Word stores, then every load kind at every legal offset
    start = errors;
    for (int w = 0; w < 6; w++)
    begin
      r    = next_random();
      addr = {22'h0, r[7:0], 2'b00};
      word = next_random();
      word_addr[w] = addr;
      issue(make_insn(rv_tail_pkg::opc_store, 3'b010, 5'd0), 1'b0, 32'h0, addr, '0,
            1'b1, 1'b1, word);
      for (int b = 0; b < 4; b++)
      begin
        shadow_mem[addr[9:0] + 10'(b)] = word[8*b +: 8];
      end
    end
    for (int w = 0; w < 6; w++)
    begin
      for (int k = 0; k < 5; k++)
      begin
        for (int off = 0; off < 4; off += (1 << kinds[k][1:0]))
        begin
          addr = word_addr[w] + 32'(off);
          rd   = pick_rd(next_random());
          issue(make_insn(rv_tail_pkg::opc_load, kinds[k], rd), 1'b0, next_random(), addr,
                '0, 1'b1, 1'b0, 32'h0);
          check_value("wb_memq_o", last_memq, expect_load(kinds[k], addr));
          shadow_regs[rd] = expect_load(kinds[k], addr);
          check_reg(rd);
        end
      end
    end
    // Word index past the end of memory
    r    = next_random();
    addr = 32'h400 + {22'h0, r[7:0], 2'b00};
    rd   = pick_rd(next_random());
    issue(make_insn(rv_tail_pkg::opc_load, 3'b010, rd), 1'b0, 32'h0, addr, '0,
          1'b1, 1'b0, 32'h0);
    check_fault(rd, LATENCY, one_fault(FLT_LD_AF), addr);
    issue(make_insn(rv_tail_pkg::opc_store, 3'b010, 5'd0), 1'b0, 32'h0, addr + 32'd4, '0,
          1'b1, 1'b1, next_random());
    check_fault(rd, LATENCY, one_fault(FLT_ST_AF), addr + 32'd4);
    end_test("stores and loads", start);

    // Stall length and pc hold on aligned accesses
    start = errors;
    for (int n = 0; n < 4; n++)
    begin
      addr = word_addr[n];
      issue(make_insn(n[0] ? rv_tail_pkg::opc_store : rv_tail_pkg::opc_load, 3'b010, 5'd0),
            1'b0, 32'h0, addr, '0, 1'b1, n[0], expect_load(3'b010, addr));
      check_value("stall cycles", 32'(stall_cycles), 32'(LATENCY));
    end
    end_test("stall timing", start);

    // Misaligned lh, lw and sw answer at once
    start = errors;
    rd   = pick_rd(next_random());
    addr = word_addr[0] + 32'd1;
    issue(make_insn(rv_tail_pkg::opc_load, 3'b001, rd), 1'b0, 32'h0, addr, '0,
          1'b1, 1'b0, 32'h0);
    check_fault(rd, 0, one_fault(FLT_MIS_LD), addr);
    addr = word_addr[1] + 32'd2;
    issue(make_insn(rv_tail_pkg::opc_load, 3'b010, rd), 1'b0, 32'h0, addr, '0,
          1'b1, 1'b0, 32'h0);
    check_fault(rd, 0, one_fault(FLT_MIS_LD), addr);
    addr = word_addr[2] + 32'd3;
    issue(make_insn(rv_tail_pkg::opc_store, 3'b010, 5'd0), 1'b0, 32'h0, addr, '0,
          1'b1, 1'b1, next_random());
    check_fault(rd, 0, one_fault(FLT_MIS_ST), addr);
    end_test("memory faults", start);

    // Incoming illegal instruction and breakpoint
    start = errors;
    word = next_random();
    issue(word, 1'b0, next_random(), 32'h0, one_fault(FLT_ILLEGAL), 1'b0, 1'b0, 32'h0);
    check_fault(word[11:7], 0, one_fault(FLT_ILLEGAL), word);
    rd   = pick_rd(next_random());
    addr = word_addr[3];
    issue(make_insn(rv_tail_pkg::opc_load, 3'b010, rd), 1'b0, 32'h0, addr,
          one_fault(FLT_BREAK), 1'b0, 1'b0, 32'h0);
    check_fault(rd, 0, one_fault(FLT_BREAK), addr);
    end_test("incoming exceptions", start);

    errors = errors + assert_errors;
    $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    done = 1'b1;
  end

  // Watchdog that ends the run
  initial
  begin
    int cycles;
    cycles = 0;
    while (!done && !timed_out && cycles < RUN_LIMIT)
    begin
      @(negedge clk_i);
      cycles++;
    end
    if (!done && !timed_out)
      $display("Timeout, run did not finish within %0d cycles", RUN_LIMIT);
    if (done && !timed_out && errors == 0 && tests_failed == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
src/rv_tail_pkg.sv
src/rv_dmem.sv
src/rv_wb.sv
src/rv_regfile.sv
src/rv_mem_tail.sv
tb/tb_rv_mem_tail.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_rv_mem_tail -f sim.f > sim.log 2>&1 \
  && ./obj_dir/Vtb_rv_mem_tail >> sim.log 2>&1 \
  || { echo "Build or run error, see sim.log"; exit 1; }
if grep -q "Simulation failed" sim.log
then
  echo "FAIL, see sim.log"
  exit 1
fi
echo "PASS"
exit 0
